/* rtl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 8;
	localparam int addrWidth = 8;
	localparam int memDepth = 256;
	localparam int bootLength = 16;

	typedef logic [dataWidth-1:0] dataT;
	typedef logic [addrWidth-1:0] addrT;

	// High nibble of the first instruction byte.
	typedef enum logic [3:0] {
		opNop = 4'h0,
		opLdi = 4'h1,
		opLda = 4'h2,
		opSta = 4'h3,
		opAdd = 4'h4,
		opSub = 4'h5,
		opAnd = 4'h6,
		opOr  = 4'h7,
		opXor = 4'h8,
		opJmp = 4'h9,
		opJz  = 4'hA,
		opJc  = 4'hB,
		opHlt = 4'hF
	} opcodeT;

	typedef enum logic [2:0] {
		aluPass = 3'd0,
		aluAdd  = 3'd1,
		aluSub  = 3'd2,
		aluAnd  = 3'd3,
		aluOr   = 3'd4,
		aluXor  = 3'd5
	} aluOpT;

	typedef enum logic [2:0] {
		stIdle    = 3'd0,
		stFetch   = 3'd1,
		stOperand = 3'd2,
		stExecute = 3'd3,
		stHalt    = 3'd4
	} ctrlStateT;

	localparam addrT debugAddr = 8'd127;

	// Sum of the two data bytes goes to 127, then XOR with the first one.
	localparam dataT bootImage [0:bootLength-1] = '{
		8'h20, 8'h0E,	// LDA 14.
		8'h40, 8'h0F,	// ADD 15.
		8'h30, 8'h7F,	// STA 127.
		8'h80, 8'h0E,	// XOR 14.
		8'hF0, 8'h00,	// HLT.
		8'h00, 8'h00,
		8'h00, 8'h00,
		8'h2A, 8'hE0	// Data bytes.
	};

endpackage

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpuPkg::dataT  a,
	input  cpuPkg::dataT  b,
	input  cpuPkg::aluOpT op,
	output cpuPkg::dataT  result,
	output logic          carryOut
);

	// One extra bit on top for carry or borrow.
	logic [cpuPkg::dataWidth:0] wide;

	always_comb begin
		case (op)
			cpuPkg::aluPass: begin
				wide = {1'b0, b};
			end
			cpuPkg::aluAdd: begin
				wide = {1'b0, a} + {1'b0, b};
			end
			cpuPkg::aluSub: begin
				wide = {1'b0, a} - {1'b0, b};	// Top bit set when a < b.
			end
			cpuPkg::aluAnd: begin
				wide = {1'b0, a & b};
			end
			cpuPkg::aluOr: begin
				wide = {1'b0, a | b};
			end
			cpuPkg::aluXor: begin
				wide = {1'b0, a ^ b};
			end
			default: begin
				wide = {1'b0, b};
			end
		endcase
	end

	assign result   = wide[cpuPkg::dataWidth-1:0];
	assign carryOut = wide[cpuPkg::dataWidth];

endmodule

`default_nettype wire

/* rtl/programMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module programMemory (
	input  logic         clk,
	input  logic         nRst,
	input  cpuPkg::addrT cpuAddr,
	input  logic         cpuWe,
	input  cpuPkg::dataT cpuData,
	input  logic         hostWe,
	input  cpuPkg::addrT hostAddr,
	input  cpuPkg::dataT hostData,
	output cpuPkg::dataT readData,
	output cpuPkg::dataT debugByte
);

	cpuPkg::dataT mem [0:cpuPkg::memDepth-1];

	cpuPkg::addrT wrAddr;
	cpuPkg::dataT wrData;
	logic         wrEn;

	// Host port wins over the processor.
	assign wrEn   = hostWe | cpuWe;
	assign wrAddr = hostWe ? hostAddr : cpuAddr;
	assign wrData = hostWe ? hostData : cpuData;

	assign readData  = mem[cpuAddr];	// Asynchronous read.
	assign debugByte = mem[cpuPkg::debugAddr];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < cpuPkg::bootLength; i++) begin
				mem[i] <= cpuPkg::bootImage[i];
			end
			for (int i = cpuPkg::bootLength; i < cpuPkg::memDepth; i++) begin
				mem[i] <= '0;
			end
		end else begin
			if (wrEn) begin
				mem[wrAddr] <= wrData;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input  logic          clk,
	input  logic          nRst,
	input  cpuPkg::aluOpT aluOp,
	input  cpuPkg::dataT  aluB,
	input  logic          accLoad,
	input  logic          flagLoad,
	input  logic          accClear,
	output cpuPkg::dataT  acc,
	output logic          zero,
	output logic          carry
);

	cpuPkg::dataT aluResult;
	logic         aluCarry;

	alu uAlu (
		.a        (acc),
		.b        (aluB),
		.op       (aluOp),
		.result   (aluResult),
		.carryOut (aluCarry)
	);

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc   <= '0;
			zero  <= 1'b0;
			carry <= 1'b0;
		end else if (accClear) begin
			acc   <= '0;
			zero  <= 1'b0;
			carry <= 1'b0;
		end else begin
			if (accLoad) begin
				acc <= aluResult;
			end
			if (flagLoad) begin
				zero <= (aluResult == '0);
				// Loads keep carry.
				if (aluOp != cpuPkg::aluPass) begin
					carry <= aluCarry;	// Logic ops give zero here.
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input  logic          clk,
	input  logic          nRst,
	input  logic          run,
	input  cpuPkg::dataT  readData,
	input  logic          zero,
	input  logic          carry,
	output cpuPkg::addrT  memAddr,
	output logic          memWe,
	output cpuPkg::aluOpT aluOp,
	output cpuPkg::dataT  aluB,
	output logic          accLoad,
	output logic          flagLoad,
	output logic          accClear,
	output logic          halted
);

	cpuPkg::ctrlStateT state;
	cpuPkg::ctrlStateT stateNext;
	cpuPkg::addrT      pc;
	cpuPkg::dataT      ir;
	cpuPkg::dataT      opr;
	cpuPkg::opcodeT    opcode;

	logic execute;
	logic aluWrite;
	logic storeOp;
	logic haltOp;
	logic jumpTaken;

	assign opcode = cpuPkg::opcodeT'(ir[7:4]);	// Low nibble ignored.

	always_comb begin
		aluOp     = cpuPkg::aluPass;
		aluWrite  = 1'b0;
		storeOp   = 1'b0;
		haltOp    = 1'b0;
		jumpTaken = 1'b0;
		case (opcode)
			cpuPkg::opLdi, cpuPkg::opLda: begin
				aluWrite = 1'b1;
			end
			cpuPkg::opSta: begin
				storeOp = 1'b1;
			end
			cpuPkg::opAdd: begin
				aluOp    = cpuPkg::aluAdd;
				aluWrite = 1'b1;
			end
			cpuPkg::opSub: begin
				aluOp    = cpuPkg::aluSub;
				aluWrite = 1'b1;
			end
			cpuPkg::opAnd: begin
				aluOp    = cpuPkg::aluAnd;
				aluWrite = 1'b1;
			end
			cpuPkg::opOr: begin
				aluOp    = cpuPkg::aluOr;
				aluWrite = 1'b1;
			end
			cpuPkg::opXor: begin
				aluOp    = cpuPkg::aluXor;
				aluWrite = 1'b1;
			end
			cpuPkg::opJmp: jumpTaken = 1'b1;
			cpuPkg::opJz:  jumpTaken = zero;
			cpuPkg::opJc:  jumpTaken = carry;
			cpuPkg::opHlt: haltOp = 1'b1;
			default:       aluWrite = 1'b0;	// NOP and unused codes.
		endcase
	end

	assign execute  = (state == cpuPkg::stExecute) && run;
	assign accLoad  = execute && aluWrite;
	assign flagLoad = execute && aluWrite;
	assign memWe    = execute && storeOp;
	assign accClear = (state == cpuPkg::stIdle) && run;
	assign halted   = (state == cpuPkg::stHalt);

	// Operand is the data address during execute.
	assign memAddr = (state == cpuPkg::stExecute) ? opr : pc;
	assign aluB    = (opcode == cpuPkg::opLdi) ? opr : readData;

	always_comb begin
		stateNext = state;
		case (state)
			cpuPkg::stIdle:    if (run) stateNext = cpuPkg::stFetch;
			cpuPkg::stFetch:   stateNext = cpuPkg::stOperand;
			cpuPkg::stOperand: stateNext = cpuPkg::stExecute;
			cpuPkg::stExecute: stateNext = haltOp ? cpuPkg::stHalt : cpuPkg::stFetch;
			cpuPkg::stHalt:    stateNext = cpuPkg::stHalt;
			default:           stateNext = cpuPkg::stIdle;
		endcase
		if (!run) begin
			stateNext = cpuPkg::stIdle;	// Stop from anywhere.
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= cpuPkg::stIdle;
			pc    <= '0;
		end else begin
			state <= stateNext;
			if (accClear) begin
				pc <= '0;
			end else if (run && (state == cpuPkg::stFetch || state == cpuPkg::stOperand)) begin
				pc <= pc + 8'd1;
			end else if (execute && jumpTaken) begin
				pc <= opr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == cpuPkg::stFetch) begin
			ir <= readData;
		end
		if (state == cpuPkg::stOperand) begin
			opr <= readData;
		end
	end

endmodule

`default_nettype wire

/* rtl/microTop.sv */
`timescale 1ns/1ps
`default_nettype none

module microTop (
	input  logic         clk,
	input  logic         nRst,
	input  logic         run,
	input  logic         hostWe,
	input  cpuPkg::addrT hostAddr,
	input  cpuPkg::dataT hostData,
	output cpuPkg::dataT acc,
	output logic         zero,
	output logic         carry,
	output logic         halted,
	output cpuPkg::dataT debugByte
);

	cpuPkg::addrT  memAddr;
	logic          memWe;
	cpuPkg::dataT  readData;
	cpuPkg::aluOpT aluOp;
	cpuPkg::dataT  aluB;
	logic          accLoad;
	logic          flagLoad;
	logic          accClear;

	programMemory uMem (
		.clk       (clk),
		.nRst      (nRst),
		.cpuAddr   (memAddr),
		.cpuWe     (memWe),
		.cpuData   (acc),	// Store data comes from the accumulator.
		.hostWe    (hostWe),
		.hostAddr  (hostAddr),
		.hostData  (hostData),
		.readData  (readData),
		.debugByte (debugByte)
	);

	controlUnit uCtrl (
		.clk      (clk),
		.nRst     (nRst),
		.run      (run),
		.readData (readData),
		.zero     (zero),
		.carry    (carry),
		.memAddr  (memAddr),
		.memWe    (memWe),
		.aluOp    (aluOp),
		.aluB     (aluB),
		.accLoad  (accLoad),
		.flagLoad (flagLoad),
		.accClear (accClear),
		.halted   (halted)
	);

	datapath uData (
		.clk      (clk),
		.nRst     (nRst),
		.aluOp    (aluOp),
		.aluB     (aluB),
		.accLoad  (accLoad),
		.flagLoad (flagLoad),
		.accClear (accClear),
		.acc      (acc),
		.zero     (zero),
		.carry    (carry)
	);

endmodule

`default_nettype wire

/* verification/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int modelStepLimit = 200;

cpuPkg::dataT shadowMem [0:cpuPkg::memDepth-1];
logic [31:0]  rngState;

function automatic void initShadow();
	for (int i = 0; i < cpuPkg::memDepth; i++) begin
		if (i < cpuPkg::bootLength) begin
			shadowMem[i] = cpuPkg::bootImage[i];
		end else begin
			shadowMem[i] = 8'h00;
		end
	end
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [31:0] nextRandom();
	rngState = xorshift(rngState);
	return rngState;
endfunction

// Runs the shadow memory from address 0 until HLT; returns 0 if it never halts.
function automatic bit runModel(output cpuPkg::dataT accOut, output logic zeroOut,
		output logic carryOut, output cpuPkg::dataT debugOut, output int count);
	cpuPkg::addrT pc;
	cpuPkg::dataT instr;
	cpuPkg::dataT operand;
	cpuPkg::dataT m;
	cpuPkg::dataT a;
	logic         z;
	logic         c;
	bit           halt;
	pc = 8'h00;
	a = 8'h00;
	z = 1'b0;
	c = 1'b0;
	halt = 1'b0;
	count = 0;
	while (!halt && count < modelStepLimit) begin
		instr = shadowMem[pc];
		pc = pc + 8'd1;
		operand = shadowMem[pc];
		pc = pc + 8'd1;
		m = shadowMem[operand];
		count++;
		case (instr[7:4])
			4'h1: a = operand;
			4'h2: a = m;
			4'h3: shadowMem[operand] = a;
			4'h4: begin
				c = (int'(a) + int'(m)) > 255;
				a = a + m;
			end
			4'h5: begin
				c = a < m;	// Borrow.
				a = a - m;
			end
			4'h6: begin
				a = a & m;
				c = 1'b0;
			end
			4'h7: begin
				a = a | m;
				c = 1'b0;
			end
			4'h8: begin
				a = a ^ m;
				c = 1'b0;
			end
			4'h9: pc = operand;
			4'hA: begin
				if (z) begin
					pc = operand;
				end
			end
			4'hB: begin
				if (c) begin
					pc = operand;
				end
			end
			4'hF: halt = 1'b1;
			default: ;
		endcase
		if (instr[7:4] inside {4'h1, 4'h2, [4'h4:4'h8]}) begin
			z = (a == 8'h00);
		end
	end
	accOut = a;
	zeroOut = z;
	carryOut = c;
	debugOut = shadowMem[cpuPkg::debugAddr];
	return halt;
endfunction

`endif

/* verification/microTopTb.sv */
`timescale 1ns/1ps
`default_nettype none

module microTopTb;

	localparam int timeoutCycles = 1000;
	localparam logic [3:0] aluCodes [0:6] = '{4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h7, 4'h8};

	logic         clk;
	logic         nRst;
	logic         run;
	logic         hostWe;
	cpuPkg::addrT hostAddr;
	cpuPkg::dataT hostData;
	cpuPkg::dataT acc;
	logic         zero;
	logic         carry;
	logic         halted;
	cpuPkg::dataT debugByte;

	int           errors;
	int           checks;
	cpuPkg::dataT progBuf [0:15];

	`include "cpuModel.svh"

	microTop u_dut (
		.clk       (clk),
		.nRst      (nRst),
		.run       (run),
		.hostWe    (hostWe),
		.hostAddr  (hostAddr),
		.hostData  (hostData),
		.acc       (acc),
		.zero      (zero),
		.carry     (carry),
		.halted    (halted),
		.debugByte (debugByte)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	task automatic checkData(input string name, input cpuPkg::dataT expected,
			input cpuPkg::dataT actual);
		checks++;
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic writeByte(input cpuPkg::addrT addr, input cpuPkg::dataT data);
		@(posedge clk);
		hostWe   <= 1'b1;
		hostAddr <= addr;
		hostData <= data;
		shadowMem[addr] = data;	// Model follows every host write.
	endtask

	task automatic setStep(input int idx, input cpuPkg::dataT op, input cpuPkg::dataT arg);
		progBuf[2*idx]   = op;
		progBuf[2*idx+1] = arg;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < 16; i++) begin
			writeByte(cpuPkg::addrT'(i), progBuf[i]);
		end
		@(posedge clk);
		hostWe <= 1'b0;
	endtask

	// Edge count starts at the first edge that sees run high.
	task automatic startAndWait(output int edges, output bit done);
		edges = 0;
		done = 1'b0;
		@(posedge clk);
		run <= 1'b1;
		while (!done && edges < timeoutCycles) begin
			@(posedge clk);
			#1;
			edges++;
			done = halted;
		end
	endtask

	task automatic stopRun(input string name);
		int waited;
		waited = 0;
		@(posedge clk);
		run <= 1'b0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (halted && waited < timeoutCycles);
		checks++;
		if (halted) begin
			$display("%s: halted did not fall after run was lowered", name);
			errors++;
		end
	endtask

	task automatic runAndCompare(input string name);
		cpuPkg::dataT expAcc;
		cpuPkg::dataT expDebug;
		logic         expZero;
		logic         expCarry;
		int           expCount;
		int           edges;
		bit           modelHalted;
		bit           done;
		modelHalted = runModel(expAcc, expZero, expCarry, expDebug, expCount);
		if (!modelHalted) begin
			$display("%s: program did not halt within %0d instructions", name, modelStepLimit);
			errors++;
		end
		startAndWait(edges, done);
		if (!done) begin
			$display("%s: halted did not rise within %0d cycles", name, timeoutCycles);
			errors++;
		end else begin
			checkData({name, " acc"}, expAcc, acc);
			checkFlag({name, " zero"}, expZero, zero);
			checkFlag({name, " carry"}, expCarry, carry);
			checkData({name, " debugByte"}, expDebug, debugByte);
			checkCount({name, " cycles"}, 3 * expCount + 1, edges);
		end
		stopRun(name);
	endtask

	initial begin
		logic [31:0]  rnd;
		logic [3:0]   nib;
		cpuPkg::dataT arg;
		nRst = 1'b0;
		run = 1'b0;
		hostWe = 1'b0;
		hostAddr = 8'h00;
		hostData = 8'h00;
		errors = 0;
		checks = 0;
		rngState = 32'd59;
		initShadow();
		repeat (10) @(posedge clk);
		nRst <= 1'b1;
		@(posedge clk);
		#1;

		checkData("reset debugByte", 8'h00, debugByte);
		checkData("reset acc", 8'h00, acc);
		checkFlag("reset halted", 1'b0, halted);
		runAndCompare("boot");
		checkData("boot debugByte", 8'h0A, debugByte);
		checkData("boot acc", 8'h20, acc);

		writeByte(8'h40, 8'h50);
		writeByte(8'h41, 8'h20);
		writeByte(8'h42, 8'h0F);
		writeByte(8'h43, 8'h30);
		writeByte(8'h44, 8'h38);
		setStep(0, 8'h10, 8'hC8);
		setStep(1, 8'h40, 8'h40);	// Carry out.
		setStep(2, 8'h50, 8'h41);	// Borrow.
		setStep(3, 8'h60, 8'h42);
		setStep(4, 8'h70, 8'h43);
		setStep(5, 8'h80, 8'h44);	// Zero result.
		setStep(6, 8'h30, 8'h7F);
		setStep(7, 8'hF0, 8'h00);
		loadProgram();
		runAndCompare("alu mix");

		writeByte(8'h45, 8'hF0);
		for (int t = 0; t < 4; t++) begin
			setStep(0, 8'h10, (t == 0 || t == 3) ? 8'hF0 : 8'h20);
			setStep(1, (t == 0 || t == 3) ? 8'h50 : 8'h40, 8'h45);	// Zero and carry differ.
			setStep(2, (t < 2) ? 8'hA0 : 8'hB0, 8'h0A);
			setStep(3, 8'h10, 8'h11);	// Fall-through marker.
			setStep(4, 8'h90, 8'h0C);
			setStep(5, 8'h10, 8'h22);	// Taken marker.
			setStep(6, 8'h30, 8'h7F);
			setStep(7, 8'hF0, 8'h00);
			loadProgram();
			runAndCompare($sformatf("jump %0d", t));
			checkData($sformatf("jump %0d marker", t), (t % 2 == 0) ? 8'h22 : 8'h11, debugByte);
		end

		writeByte(8'h46, 8'h01);
		setStep(0, 8'h10, 8'h03);
		setStep(1, 8'h50, 8'h46);	// Count down to zero.
		setStep(2, 8'hA0, 8'h08);
		setStep(3, 8'h90, 8'h02);
		setStep(4, 8'h30, 8'h7F);
		setStep(5, 8'hF0, 8'h00);
		loadProgram();
		runAndCompare("timing loop");

		for (int p = 0; p < 20; p++) begin
			for (int k = 0; k < 16; k++) begin
				rnd = nextRandom();
				writeByte(cpuPkg::addrT'(8'h40 + k), rnd[7:0]);
			end
			for (int s = 0; s < 6; s++) begin
				rnd = nextRandom();
				nib = aluCodes[int'(rnd[15:8] % 8'd7)];
				arg = (nib == 4'h1) ? rnd[23:16] : {4'h4, rnd[19:16]};
				setStep(s, {nib, rnd[3:0]}, arg);	// Random low nibble.
			end
			setStep(6, 8'h30, 8'h7F);
			setStep(7, 8'hF0, 8'h00);
			loadProgram();
			runAndCompare($sformatf("random %0d", p));
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* microCpu.f */
+incdir+verification
rtl/cpuPkg.sv
rtl/alu.sv
rtl/programMemory.sv
rtl/datapath.sv
rtl/controlUnit.sv
rtl/microTop.sv
verification/microTopTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass line.

cd "$(dirname "$0")" &&
verilator --binary --timing --top-module microTopTb -f microCpu.f -o microTopTbSim &&
./obj_dir/microTopTbSim | tee /dev/stderr | grep -qx "ALL TESTS PASSED" &&
echo "Simulation passed." ||
{ echo "Simulation failed." >&2; exit 1; }
